/* rtl/capMemPkg.sv */
////////////////////////////////////////////////////////////////////////////
// Memory data types
// Widths and word layout shared by every block on the data path
////////////////////////////////////////////////////////////////////////////

package capMemPkg;

   // User data width in bits
   localparam int DATA_W = 8;

   // Word address width in bits
   // Sets the upper limit for the array depth
   localparam int ADDR_W = 6;

   // User data word as seen on the write port
   typedef logic [DATA_W-1:0] capData_t;

   // Word address shared by reads and writes
   typedef logic [ADDR_W-1:0] capAddr_t;

   // Stored and returned word
   // Parity sits above the data, so the packed layout is {parity, data}
   typedef struct packed {
      // Even parity over data, or the caller's bit on override writes
      logic     parity;
      // Data as written, bit 0 flipped on hardware override writes
      capData_t data;
   } capWord_t;

endpackage

/* rtl/capCtlPkg.sv */
////////////////////////////////////////////////////////////////////////////
// Control and status types
// Write origin, error capture record and capture FSM states
////////////////////////////////////////////////////////////////////////////

package capCtlPkg;

   // Origin and protection mode of one write
   typedef struct packed {
      // Write comes from hardware rather than software
      logic hwActive;
      // Bypass normal parity generation
      logic protOverride;
      // Parity bit supplied by software on override writes
      logic paritySyndromeIn;
   } capWrCtl_t;

   // Sticky record of the first parity error
   typedef struct packed {
      // Set once an error has been captured
      logic                captured;
      // Word address of the failing read
      capMemPkg::capAddr_t addr;
      // Stored parity XOR recomputed parity
      logic                syndrome;
   } capErrStatus_t;

   // Capture FSM states
   typedef enum logic [0:0] {
      CAP_IDLE = 1'b0,
      CAP_HELD = 1'b1
   } capCapState_e;

endpackage

/* rtl/CapParityGen.sv */
`timescale 1ns/1ps

////////////////////////////////////////////////////////////////////////////
// Write-side parity generator
// Builds the stored word from the raw data and the write control
////////////////////////////////////////////////////////////////////////////

module CapParityGen (
   input  capMemPkg::capData_t  wrData,
   input  capCtlPkg::capWrCtl_t wrCtl,
   output capMemPkg::capWord_t  genWord
);

   // Software override takes the caller's parity bit
   logic                swOverride;
   // Hardware override plants a single-bit data error
   logic                hwInject;
   logic                parityBit;
   capMemPkg::capData_t dataOut;

   assign swOverride = wrCtl.protOverride & ~wrCtl.hwActive;
   assign hwInject   = wrCtl.protOverride & wrCtl.hwActive;

   // Even parity always covers the raw data
   // so an injected flip shows up as a mismatch on read
   assign parityBit = swOverride ? wrCtl.paritySyndromeIn : ^wrData;

   // Only bit 0 is ever touched
   assign dataOut = wrData ^ {{(capMemPkg::DATA_W-1){1'b0}}, hwInject};

   // Pack into the stored word layout
   assign genWord.parity = parityBit;
   assign genWord.data   = dataOut;

endmodule

/* rtl/CapMemArray.sv */
`timescale 1ns/1ps

////////////////////////////////////////////////////////////////////////////
// Single-port storage array
// Registered read, read-before-write on address collision
////////////////////////////////////////////////////////////////////////////

module CapMemArray #(
   parameter int MEM_DEPTH = 48
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                wrEn,
   input  logic                rdEn,
   input  capMemPkg::capAddr_t addr,
   input  capMemPkg::capWord_t wrWord,
   output capMemPkg::capWord_t rdWord,
   output logic                rdValid,
   output capMemPkg::capAddr_t rdAddr
);

   // Storage for data plus parity
   capMemPkg::capWord_t mem [MEM_DEPTH];

   // Write port
   // Word is stored on the edge where wrEn is sampled high
   always_ff @(posedge clk) begin
      if (wrEn) begin
         mem[addr] <= wrWord;
      end
   end

   // Read data and address
   // Nonblocking read of mem returns the old word on a same-cycle write
   always_ff @(posedge clk) begin
      if (rdEn) begin
         rdWord <= mem[addr];
         // Address rides along for the error capture
         rdAddr <= addr;
      end
   end

   // Read valid strobe
   // High for exactly one cycle after each rdEn
   always_ff @(posedge clk) begin
      if (rst) begin
         rdValid <= 1'b0;
      end else begin
         rdValid <= rdEn;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Assertions
   ////////////////////////////////////////////////////////////////////////////

   // Any enabled access must land inside the populated depth
   property pAddrInRange;
      @(posedge clk) disable iff (rst)
         (wrEn || rdEn) |-> (int'(addr) < MEM_DEPTH);
   endproperty

   aAddrInRange : assert property (pAddrInRange)
      else $error("CapMemArray access at address %0d beyond depth %0d", addr, MEM_DEPTH);

   // No stale read strobe leaks out of reset
   property pRdValidAfterRst;
      @(posedge clk)
         rst |=> !rdValid;
   endproperty

   aRdValidAfterRst : assert property (pRdValidAfterRst)
      else $error("CapMemArray rdValid high right after reset");

endmodule

/* rtl/CapParityCheck.sv */
`timescale 1ns/1ps

////////////////////////////////////////////////////////////////////////////
// Read-side parity checker
// Flags mismatches and holds the first error until software clears it
////////////////////////////////////////////////////////////////////////////

module CapParityCheck (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     rdValid,
   input  capMemPkg::capWord_t      rdWord,
   input  capMemPkg::capAddr_t      rdAddr,
   input  logic                     errClear,
   output logic                     parityErr,
   output capCtlPkg::capErrStatus_t errStatus
);

   // Recomputed even parity of the returned data
   logic                     calcParity;
   // Stored parity against recomputed parity
   logic                     syndrome;
   // Capture FSM
   capCtlPkg::capCapState_e  capState;
   capCtlPkg::capCapState_e  capStateNext;
   // Status load strobe and the record it loads
   logic                     loadStatus;
   capCtlPkg::capErrStatus_t newStatus;

   ////////////////////////////////////////////////////////////////////////////
   // Parity recompute
   ////////////////////////////////////////////////////////////////////////////

   assign calcParity = ^rdWord.data;
   assign syndrome   = rdWord.parity ^ calcParity;

   // Only meaningful on the cycle the array presents a word
   assign parityErr = rdValid & syndrome;

   ////////////////////////////////////////////////////////////////////////////
   // Capture FSM
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      capStateNext = capState;
      case (capState)
         capCtlPkg::CAP_IDLE: begin
            if (parityErr) begin
               capStateNext = capCtlPkg::CAP_HELD;
            end
         end
         capCtlPkg::CAP_HELD: begin
            // Sticky until software steps in
            capStateNext = capCtlPkg::CAP_HELD;
         end
         default: begin
            capStateNext = capCtlPkg::CAP_IDLE;
         end
      endcase
      // Clear beats a new error in the same cycle
      if (errClear) begin
         capStateNext = capCtlPkg::CAP_IDLE;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         capState <= capCtlPkg::CAP_IDLE;
      end else begin
         capState <= capStateNext;
      end
   end

   // First error only
   assign loadStatus = (capState == capCtlPkg::CAP_IDLE) & parityErr & ~errClear;

   assign newStatus.captured = 1'b1;
   assign newStatus.addr     = rdAddr;
   assign newStatus.syndrome = syndrome;

   // Status register, visible the cycle after the failing read
   always_ff @(posedge clk) begin
      if (rst || errClear) begin
         errStatus <= '0;
      end else if (loadStatus) begin
         errStatus <= newStatus;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Assertions
   ////////////////////////////////////////////////////////////////////////////

   // Held record is frozen until a clear arrives
   aStatusHeld : assert property (
      @(posedge clk) disable iff (rst)
         (capState == capCtlPkg::CAP_HELD && !errClear) |=> $stable(errStatus)
   ) else $error("CapParityCheck status changed while held");

   // An error can only come with a returned word
   aErrNeedsValid : assert property (
      @(posedge clk) disable iff (rst)
         parityErr |-> rdValid
   ) else $error("CapParityCheck parityErr without rdValid");

endmodule

/* rtl/CapMemWrapper.sv */
`timescale 1ns/1ps

////////////////////////////////////////////////////////////////////////////
// Parity-protected single-port memory
// Generator on the write side, storage array, checker on the read side
////////////////////////////////////////////////////////////////////////////

module CapMemWrapper #(
   // Number of populated entries, at most 2**ADDR_W
   parameter int MEM_DEPTH = 48
) (
   input  logic                     clk,
   input  logic                     rst,
   // Write request
   input  logic                     wrEn,
   input  capMemPkg::capData_t      wrData,
   input  capCtlPkg::capWrCtl_t     wrCtl,
   // Read request
   input  logic                     rdEn,
   // Shared by reads and writes
   input  capMemPkg::capAddr_t      addr,
   // One-cycle pulse that releases the status record
   input  logic                     errClear,
   // Read response, one cycle after rdEn
   output logic                     rdValid,
   output capMemPkg::capWord_t      rdWord,
   output logic                     parityErr,
   // Sticky first-error record
   output capCtlPkg::capErrStatus_t errStatus
);

   // Word headed for storage
   capMemPkg::capWord_t genWord;

   // Registered read response from the array
   capMemPkg::capWord_t memRdWord;
   logic                memRdValid;
   capMemPkg::capAddr_t memRdAddr;

   ////////////////////////////////////////////////////////////////////////////
   // Write side
   ////////////////////////////////////////////////////////////////////////////

   // Parity is added in the same cycle as the write
   CapParityGen parityGen_i (
      .wrData  (wrData),
      .wrCtl   (wrCtl),
      .genWord (genWord)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Storage
   ////////////////////////////////////////////////////////////////////////////

   CapMemArray #(
      .MEM_DEPTH (MEM_DEPTH)
   ) memArray_i (
      .clk     (clk),
      .rst     (rst),
      .wrEn    (wrEn),
      .rdEn    (rdEn),
      .addr    (addr),
      .wrWord  (genWord),
      .rdWord  (memRdWord),
      .rdValid (memRdValid),
      .rdAddr  (memRdAddr)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Read side
   ////////////////////////////////////////////////////////////////////////////

   // Checks the same word that goes out to the caller
   CapParityCheck parityCheck_i (
      .clk       (clk),
      .rst       (rst),
      .rdValid   (memRdValid),
      .rdWord    (memRdWord),
      .rdAddr    (memRdAddr),
      .errClear  (errClear),
      .parityErr (parityErr),
      .errStatus (errStatus)
   );

   // Returned word and strobe come straight from the array
   // with the stored parity bit left intact
   assign rdWord  = memRdWord;
   assign rdValid = memRdValid;

endmodule

/* verif/capTbVectors.svh */
`ifndef CAP_TB_VECTORS_SVH
`define CAP_TB_VECTORS_SVH

// Columns: operation, word address, write data, write control, test group
// Write control is {hwActive, protOverride, paritySyndromeIn}
// Expected words and error bits are filled in later by the shadow model

task automatic loadDirectedRows();
   // Group 1: plain writes, back-to-back reads, read-before-write
   addRow(OP_WR,   0, 8'h00, 3'b000, 4'd1);
   addRow(OP_WR,   1, 8'hA5, 3'b000, 4'd1);
   addRow(OP_WR,   2, 8'h01, 3'b000, 4'd1);
   addRow(OP_WR,  47, 8'hFF, 3'b000, 4'd1);
   addRow(OP_RD,   0, 8'h00, 3'b000, 4'd1);
   addRow(OP_RD,   1, 8'h00, 3'b000, 4'd1);
   addRow(OP_RD,   2, 8'h00, 3'b000, 4'd1);
   addRow(OP_RD,  47, 8'h00, 3'b000, 4'd1);
   // Same-cycle write and read, old word comes back
   addRow(OP_WRRD, 1, 8'h3C, 3'b000, 4'd1);
   addRow(OP_RD,   1, 8'h00, 3'b000, 4'd1);

   // Group 2: software override, caller's parity bit is stored
   addRow(OP_WR,   3, 8'h07, 3'b011, 4'd2);
   addRow(OP_WR,   4, 8'h07, 3'b010, 4'd2);
   addRow(OP_WR,   5, 8'h00, 3'b011, 4'd2);
   addRow(OP_WR,   6, 8'h00, 3'b010, 4'd2);
   addRow(OP_RD,   3, 8'h00, 3'b000, 4'd2);
   addRow(OP_RD,   4, 8'h00, 3'b000, 4'd2);
   addRow(OP_RD,   5, 8'h00, 3'b000, 4'd2);
   addRow(OP_RD,   6, 8'h00, 3'b000, 4'd2);

   // Group 3: hardware override flips bit 0, hardware without override is plain
   addRow(OP_WR,   7, 8'h5A, 3'b110, 4'd3);
   addRow(OP_WR,   8, 8'h80, 3'b111, 4'd3);
   addRow(OP_WR,   9, 8'h33, 3'b100, 4'd3);
   addRow(OP_RD,   7, 8'h00, 3'b000, 4'd3);
   addRow(OP_RD,   8, 8'h00, 3'b000, 4'd3);
   addRow(OP_RD,   9, 8'h00, 3'b000, 4'd3);

   // Group 4: first error held, later ones ignored, clear re-arms
   addRow(OP_CLR,  0, 8'h00, 3'b000, 4'd4);
   addRow(OP_RD,   9, 8'h00, 3'b000, 4'd4);
   addRow(OP_RD,   7, 8'h00, 3'b000, 4'd4);
   addRow(OP_RD,   8, 8'h00, 3'b000, 4'd4);
   addRow(OP_NOP,  0, 8'h00, 3'b000, 4'd4);
   addRow(OP_CLR,  0, 8'h00, 3'b000, 4'd4);
   addRow(OP_RD,   4, 8'h00, 3'b000, 4'd4);
   addRow(OP_NOP,  0, 8'h00, 3'b000, 4'd4);
   addRow(OP_CLR,  0, 8'h00, 3'b000, 4'd4);
   // Error response lands in the same cycle as the clear below
   addRow(OP_RD,   8, 8'h00, 3'b000, 4'd4);
   addRow(OP_CLR,  0, 8'h00, 3'b000, 4'd4);
   addRow(OP_RD,   7, 8'h00, 3'b000, 4'd4);
endtask

`endif

/* verif/CapMemWrapperTb.sv */
`timescale 1ns/1ps

module CapMemWrapperTb;

   localparam int MEM_DEPTH = 48;

   // Row operations
   typedef enum logic [2:0] {
      OP_NOP  = 3'd0,
      OP_WR   = 3'd1,
      OP_RD   = 3'd2,
      OP_WRRD = 3'd3,
      OP_CLR  = 3'd4
   } tbOp_e;

   // One stimulus row with its expected response
   typedef struct packed {
      tbOp_e                op;
      capMemPkg::capAddr_t  addr;
      capMemPkg::capData_t  data;
      capCtlPkg::capWrCtl_t ctl;
      capMemPkg::capWord_t  expWord;
      logic                 expErr;
      logic [3:0]           grp;
   } tbRow_t;

   // DUT ports
   logic                     clk;
   logic                     rst;
   logic                     wrEn;
   capMemPkg::capData_t      wrData;
   capCtlPkg::capWrCtl_t     wrCtl;
   logic                     rdEn;
   capMemPkg::capAddr_t      addr;
   logic                     errClear;
   logic                     rdValid;
   capMemPkg::capWord_t      rdWord;
   logic                     parityErr;
   capCtlPkg::capErrStatus_t errStatus;

   tbRow_t                   rowQ [$];
   capMemPkg::capWord_t      shadowMem [MEM_DEPTH];
   // Error bit a read of each address must raise
   logic                     shadowErr [MEM_DEPTH];
   // Response pipeline and shadow capture FSM
   logic                     rspPending;
   capMemPkg::capWord_t      rspWord;
   logic                     rspErr;
   capMemPkg::capAddr_t      rspAddr;
   logic                     errLast;
   capMemPkg::capAddr_t      errAddrLast;
   logic                     clrLast;
   capCtlPkg::capCapState_e  expState;
   capCtlPkg::capErrStatus_t expStatus;
   int                       checkCount;
   int                       errCount;
   int                       testCount;
   int                       seed;
   int                       watchNs;
   logic                     tableReady = 1'b0;

   CapMemWrapper #(
      .MEM_DEPTH (MEM_DEPTH)
   ) dut_i (
      .clk       (clk),
      .rst       (rst),
      .wrEn      (wrEn),
      .wrData    (wrData),
      .wrCtl     (wrCtl),
      .rdEn      (rdEn),
      .addr      (addr),
      .errClear  (errClear),
      .rdValid   (rdValid),
      .rdWord    (rdWord),
      .parityErr (parityErr),
      .errStatus (errStatus)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////////////////////////////////////////

   task automatic checkWord(input string what, input capMemPkg::capWord_t got,
                            input capMemPkg::capWord_t exp);
      checkCount++;
      if (got !== exp) begin
         errCount++;
         $display("ERROR @%0t ns: %s word got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic checkErr(input string what, input logic got, input logic exp);
      checkCount++;
      if (got !== exp) begin
         errCount++;
         $display("ERROR @%0t ns: %s got %b expected %b", $time, what, got, exp);
      end
   endtask

   task automatic checkStatus(input capCtlPkg::capErrStatus_t got,
                              input capCtlPkg::capErrStatus_t exp);
      checkCount++;
      if (got !== exp) begin
         errCount++;
         $display("ERROR @%0t ns: errStatus got %h expected %h (model state %s)",
                  $time, got, exp, expState.name());
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////////////////////

   function automatic logic evenParity(input capMemPkg::capData_t d);
      logic p;
      p = 1'b0;
      for (int b = 0; b < capMemPkg::DATA_W; b++) begin
         p = p ^ d[b];
      end
      return p;
   endfunction

   // Stored word per the generation rule
   function automatic capMemPkg::capWord_t modelWord(input capMemPkg::capData_t d,
                                                     input capCtlPkg::capWrCtl_t c);
      capMemPkg::capWord_t w;
      w.data   = d;
      w.parity = evenParity(d);
      if (c.protOverride && c.hwActive) begin
         w.data[0] = ~d[0];
      end
      if (c.protOverride && !c.hwActive) begin
         w.parity = c.paritySyndromeIn;
      end
      return w;
   endfunction

   // Error bit per the write mode
   function automatic logic modelErr(input capMemPkg::capData_t d,
                                     input capCtlPkg::capWrCtl_t c);
      logic e;
      e = 1'b0;
      if (c.protOverride && c.hwActive) begin
         // Planted bit 0 flip is always caught
         e = 1'b1;
      end else if (c.protOverride) begin
         // Caller's bit only fails when it disagrees with the data
         e = (c.paritySyndromeIn != evenParity(d));
      end
      return e;
   endfunction

   task automatic addRow(input tbOp_e op, input int a, input capMemPkg::capData_t d,
                         input logic [2:0] c, input logic [3:0] g);
      tbRow_t row;
      row      = '0;
      row.op   = op;
      row.addr = a[capMemPkg::ADDR_W-1:0];
      row.data = d;
      row.ctl  = c;
      row.grp  = g;
      rowQ.push_back(row);
   endtask

   `include "capTbVectors.svh"

   // Random fill over all four hwActive and protOverride combinations
   task automatic addRandomRows();
      int rnd;
      int idx;
      int used [16];
      for (int r = 0; r < 16; r++) begin
         rnd     = $random(seed);
         idx     = (rnd & 32'h7fff_ffff) % MEM_DEPTH;
         used[r] = idx;
         rnd     = $random(seed);
         addRow(OP_WR, idx, rnd[7:0], {r[1], r[0], rnd[8]}, 4'd5);
      end
      for (int r = 0; r < 16; r++) begin
         addRow(OP_RD, used[r], 8'h00, 3'b000, 4'd5);
      end
   endtask

   // Walk the table in order against a shadow memory
   task automatic buildExpected();
      tbRow_t row;
      for (int i = 0; i < rowQ.size(); i++) begin
         row = rowQ[i];
         if (row.op == OP_RD || row.op == OP_WRRD) begin
            // Read-before-write, so look up before any update
            row.expWord = shadowMem[row.addr];
            row.expErr  = shadowErr[row.addr];
         end
         if (row.op == OP_WR || row.op == OP_WRRD) begin
            shadowMem[row.addr] = modelWord(row.data, row.ctl);
            shadowErr[row.addr] = modelErr(row.data, row.ctl);
         end
         rowQ[i] = row;
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Cycle driver
   ////////////////////////////////////////////////////////////////////////////

   task automatic stepCycle(input tbRow_t row);
      @(posedge clk);
      #1;
      // Status reflects last cycle's error and clear, clear wins
      if (clrLast) begin
         expState  = capCtlPkg::CAP_IDLE;
         expStatus = '0;
      end else if (expState == capCtlPkg::CAP_IDLE && errLast) begin
         expState           = capCtlPkg::CAP_HELD;
         expStatus.captured = 1'b1;
         expStatus.addr     = errAddrLast;
         expStatus.syndrome = 1'b1;
      end
      checkStatus(errStatus, expStatus);
      if (rspPending) begin
         if (rdValid !== 1'b1) begin
            errCount++;
            $display("Read of address %0d got no rdValid in the cycle after rdEn", rspAddr);
         end else begin
            checkWord("read", rdWord, rspWord);
            checkErr("parityErr", parityErr, rspErr);
         end
      end else begin
         if (rdValid !== 1'b0) begin
            errCount++;
            $display("rdValid went high at %0t ns with no read request", $time);
         end
         checkErr("idle parityErr", parityErr, 1'b0);
      end
      errLast     = rspPending & rspErr;
      errAddrLast = rspAddr;
      // Drive this row
      wrEn       = (row.op == OP_WR || row.op == OP_WRRD);
      rdEn       = (row.op == OP_RD || row.op == OP_WRRD);
      errClear   = (row.op == OP_CLR);
      addr       = row.addr;
      wrData     = row.data;
      wrCtl      = row.ctl;
      rspPending = rdEn;
      rspWord    = row.expWord;
      rspErr     = row.expErr;
      rspAddr    = row.addr;
      clrLast    = errClear;
   endtask

   function automatic string groupName(input int g);
      case (g)
         0: return "reset";
         1: return "normal writes";
         2: return "software override";
         3: return "hardware override";
         4: return "status capture";
         default: return "random fill";
      endcase
   endfunction

   task automatic reportTest(input int g, input int errBefore);
      testCount++;
      $display("Test %0d %s: %s (%0d errors)", g, groupName(g),
               (errCount == errBefore) ? "PASS" : "FAIL", errCount - errBefore);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence and watchdog
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      int errBefore;
      int lastIdx;
      rst        = 1'b1;
      wrEn       = 1'b0;
      // Read requested through reset, so only the reset keeps rdValid low
      rdEn       = 1'b1;
      errClear   = 1'b0;
      addr       = '0;
      wrData     = '0;
      wrCtl      = '0;
      rspPending = 1'b0;
      rspWord    = '0;
      rspErr     = 1'b0;
      rspAddr    = '0;
      errLast    = 1'b0;
      errAddrLast = '0;
      clrLast    = 1'b0;
      expState   = capCtlPkg::CAP_IDLE;
      expStatus  = '0;
      checkCount = 0;
      errCount   = 0;
      testCount  = 0;
      seed       = 6554;
      loadDirectedRows();
      addRandomRows();
      buildExpected();
      // Rows plus drain and reset cycles, then margin
      watchNs    = (rowQ.size() + 16) * 4 + 200;
      tableReady = 1'b1;
      repeat (2) @(posedge clk);
      #1;
      rst  = 1'b0;
      rdEn = 1'b0;
      errBefore = errCount;
      checkErr("rdValid after reset", rdValid, 1'b0);
      checkStatus(errStatus, '0);
      reportTest(0, errBefore);
      lastIdx = rowQ.size() - 1;
      for (int i = 0; i <= lastIdx; i++) begin
         stepCycle(rowQ[i]);
         if (i == lastIdx || rowQ[i+1].grp != rowQ[i].grp) begin
            // Two idle cycles drain the read and the status capture
            stepCycle('0);
            stepCycle('0);
            reportTest(int'(rowQ[i].grp), errBefore);
            errBefore = errCount;
         end
      end
      $display("Summary: %0d tests, %0d checks, %0d errors", testCount, checkCount, errCount);
      if (errCount == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

   initial begin
      wait (tableReady);
      #(watchNs);
      $display("Timeout: run exceeded its limit of %0d ns", watchNs);
      $display("tests failed");
      $finish;
   end

endmodule

/* files.f */
+incdir+verif
rtl/capMemPkg.sv
rtl/capCtlPkg.sv
rtl/CapParityGen.sv
rtl/CapMemArray.sv
rtl/CapParityCheck.sv
rtl/CapMemWrapper.sv
verif/CapMemWrapperTb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       := CapMemWrapperTb
FILELIST  := files.f
OBJDIR    := obj_dir
PASS_MSG  := all tests passed

BIN  := $(OBJDIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST)) verif/capTbVectors.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
